// ==== common/ctrl_if.sv ====
/* Sub-decoder result link */
interface ctrl_if
	import decode_pkg::*;
();

	logic hit; // Encoding recognised
	ctrl_t ctrl; // All zero on a miss

	// Driven by one sub-decoder
	modport decoder (
		output hit,
		output ctrl
	);

	// Read by the merge in the top level
	modport merge (
		input hit,
		input ctrl
	);

endinterface

// ==== common/decode_pkg.sv ====
/* Instruction decode definitions */
package decode_pkg;

	// Instruction field widths
	localparam int OPCODE_W = 6; // Primary opcode
	localparam int FUNCT_W = 6; // Function code
	localparam int FMT_W = 5; // COP1 format
	localparam int FT_W = 5; // COP1 ft field
	localparam int ALU_OP_W = OPCODE_W + FUNCT_W; // Opcode then funct

	// ft is a register number outside the branch format
	localparam logic [FT_W-1:0] FT_F = 5'h00; // Branch on FP false
	localparam logic [FT_W-1:0] FT_T = 5'h01; // Branch on FP true

	// Opcode numbering follows the target core, not standard MIPS
	typedef enum logic [OPCODE_W-1:0] {
		OP_J = 6'h02, // Jump
		OP_SPECIAL = 6'h03, // Register group, decoded by funct
		OP_BNE = 6'h04,
		OP_BEQ = 6'h05,
		OP_JAL = 6'h07,
		OP_ADDIU = 6'h08,
		OP_ADDI = 6'h09,
		OP_ANDI = 6'h0c,
		OP_ORI = 6'h0e,
		OP_LUI = 6'h0f,
		OP_COP1 = 6'h11, // FP group
		OP_LW = 6'h12,
		OP_LBU = 6'h22,
		OP_SB = 6'h28,
		OP_SW = 6'h2b,
		OP_LWC1 = 6'h31, // FP load single
		OP_LDC1 = 6'h35, // FP load double
		OP_SWC1 = 6'h39, // FP store single
		OP_SDC1 = 6'h3d // FP store double
	} opcode_e;

	// Integer funct codes of the special group
	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL = 6'h00,
		FN_SRL = 6'h02,
		FN_JR = 6'h08,
		FN_SW = 6'h13, // Register-addressed store
		FN_AND = 6'h14,
		FN_ADD = 6'h20,
		FN_LW = 6'h21, // Register-addressed load
		FN_SUBU = 6'h22,
		FN_SUB = 6'h24,
		FN_OR = 6'h25,
		FN_NOR = 6'h27,
		FN_SLT = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	// FP funct codes, own type since FADD shares its value with SLL
	typedef enum logic [FUNCT_W-1:0] {
		FN_FADD = 6'h00,
		FN_FCMP_A = 6'h32, // Compare variants
		FN_FCMP_B = 6'h3c,
		FN_FCMP_C = 6'h3e
	} fp_funct_e;

	typedef enum logic [FMT_W-1:0] {
		FMT_BC = 5'h08, // FP branch
		FMT_S = 5'h10, // Single precision
		FMT_D = 5'h11 // Double precision
	} fmt_e;

	typedef enum logic [1:0] {SRC_REG, SRC_SIMM, SRC_ZIMM} alu_src_e; // Second ALU operand
	typedef enum logic [1:0] {MEM_NONE, MEM_READ, MEM_WRITE} mem_op_e;
	typedef enum logic [1:0] {WB_NONE, WB_MEM, WB_LINK, WB_ALU} wb_sel_e; // Write-back source

	typedef struct packed {
		alu_src_e alu_src;
		mem_op_e mem_op;
		wb_sel_e wb_sel;
		logic jump;
		logic jump_reg;
		logic jal;
		logic branch_eq;
		logic branch_ne;
		logic bc1t;
		logic bc1f;
		logic if_flush; // Squash fetch stage
		logic id_flush; // Squash decode stage
		logic reg_dst;
		logic rt_rd;
		logic load_byte;
		logic store_byte;
		logic mem64; // 64-bit access
		logic float_op;
		logic fp_write; // Writes the FP condition flag
	} ctrl_t;

	localparam ctrl_t CTRL_NONE = '0; // No control asserted

endpackage

// ==== dv/control_unit_asserts.sv ====
/* Decode stage assertions */
module control_unit_asserts
	import decode_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic special_hit,
	input logic main_hit,
	input logic cop1_hit,
	input logic ctrl_valid,
	input logic illegal,
	input logic [ALU_OP_W-1:0] alu_op,
	input ctrl_t ctrl
);

	// Opcode groups are disjoint
	one_hit: assert property (@(posedge clk) $onehot0({special_hit, main_hit, cop1_hit}))
		else $error("More than one sub-decoder hit");

	illegal_zero: assert property (@(posedge clk) illegal |-> ctrl == CTRL_NONE)
		else $error("Controls set on an illegal instruction");

	// Illegal only marks a valid slot
	illegal_valid: assert property (@(posedge clk) illegal |-> ctrl_valid)
		else $error("Illegal flag without a valid slot");

	reset_clear: assert property (@(posedge clk) reset |=>
		(!ctrl_valid && !illegal && alu_op == '0 && ctrl == CTRL_NONE))
		else $error("Outputs not cleared after reset");

endmodule

bind control_unit control_unit_asserts u_asserts (
	.clk (clk),
	.reset (reset),
	.special_hit (special_bus.hit),
	.main_hit (main_bus.hit),
	.cop1_hit (cop1_bus.hit),
	.ctrl_valid (ctrl_valid),
	.illegal (illegal),
	.alu_op (alu_op),
	.ctrl (ctrl_q)
);

// ==== dv/control_unit_tb.sv ====
/* Decode stage testbench */
module control_unit_tb
	import decode_pkg::*;
();

	localparam int PERIOD = 20;
	localparam int RESET_CYCLES = 16;
	localparam int N_RAND = 300; // Random instructions after the table

	// One directed row with the controls expected for a valid slot
	typedef struct packed {
		logic valid;
		logic [OPCODE_W-1:0] op;
		logic [FUNCT_W-1:0] fn;
		logic [FMT_W-1:0] fm;
		logic [FT_W-1:0] f_t;
		logic ill;
		ctrl_t exp;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic instr_valid;
	logic [OPCODE_W-1:0] opcode;
	logic [FUNCT_W-1:0] funct;
	logic [FMT_W-1:0] fmt;
	logic [FT_W-1:0] ft;
	logic ctrl_valid;
	logic illegal;
	logic [ALU_OP_W-1:0] alu_op;
	alu_src_e alu_src;
	mem_op_e mem_op;
	wb_sel_e wb_sel;
	logic jump, jump_reg, jal, branch_eq, branch_ne, bc1t, bc1f, if_flush, id_flush;
	logic reg_dst, rt_rd, load_byte, store_byte, mem64, float_op, fp_write;
	ctrl_t got; // DUT outputs regrouped
	row_t rows [$];
	logic [31:0] seed = 32'hd549;

	control_unit uut (.*);

	assign got = {alu_src, mem_op, wb_sel, jump, jump_reg, jal, branch_eq, branch_ne, bc1t,
		bc1f, if_flush, id_flush, reg_dst, rt_rd, load_byte, store_byte, mem64, float_op,
		fp_write};

	always #(PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	// Flags from bit 15 down are jump jump_reg jal beq bne bc1t bc1f if_fl id_fl
	// reg_dst rt_rd load_byte store_byte mem64 float_op fp_write
	function automatic ctrl_t mk(input alu_src_e s, input mem_op_e m, input wb_sel_e w,
			input logic [15:0] f);
		return {s, m, w, f};
	endfunction

	// Expected controls straight from the decode rules
	function automatic ctrl_t model(input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] fm, input logic [4:0] f_t, output logic hit);
		ctrl_t c;
		c = CTRL_NONE;
		hit = 1'b1;
		case (op)
			OP_SPECIAL: begin
				case (fn)
					FN_SLL, FN_SRL, FN_AND, FN_ADD, FN_SUB, FN_SUBU, FN_OR, FN_NOR, FN_SLT,
					FN_SLTU: c = mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000);
					FN_JR: c = mk(SRC_REG, MEM_NONE, WB_LINK, 16'hc100);
					FN_LW: c = mk(SRC_REG, MEM_READ, WB_MEM, 16'h0060);
					FN_SW: c = mk(SRC_REG, MEM_WRITE, WB_NONE, 16'h0060);
					default: hit = 1'b0;
				endcase
			end
			OP_ADDI, OP_ADDIU: c = mk(SRC_SIMM, MEM_NONE, WB_ALU, 16'h0040);
			OP_ANDI: c = mk(SRC_ZIMM, MEM_NONE, WB_ALU, 16'h0000);
			OP_ORI, OP_LUI: c = mk(SRC_ZIMM, MEM_NONE, WB_ALU, 16'h0040);
			OP_BEQ: c = mk(SRC_REG, MEM_NONE, WB_NONE, 16'h1000);
			OP_BNE: c = mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0800);
			OP_LW: c = mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0040);
			OP_LBU: c = mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0050); // Byte load
			OP_SW: c = mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0040);
			OP_SB: c = mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0048);
			OP_J: c = mk(SRC_REG, MEM_NONE, WB_NONE, 16'h8100);
			OP_JAL: c = mk(SRC_REG, MEM_NONE, WB_LINK, 16'he100);
			OP_LWC1: c = mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0042);
			OP_LDC1: c = mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0046); // Plus mem64
			OP_SWC1: c = mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0042);
			OP_SDC1: c = mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0046);
			OP_COP1: begin
				case (fm)
					FMT_BC: begin
						case (f_t)
							FT_T: c = mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0580);
							FT_F: c = mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0380);
							default: hit = 1'b0;
						endcase
					end
					FMT_S, FMT_D: begin
						case (fn)
							FN_FADD: c = mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0002);
							FN_FCMP_A, FN_FCMP_B,
							FN_FCMP_C: c = mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0003);
							default: hit = 1'b0;
						endcase
					end
					default: hit = 1'b0;
				endcase
			end
			default: hit = 1'b0;
		endcase
		return c;
	endfunction

	task automatic compare(input string name, input logic [31:0] got_v,
			input logic [31:0] exp_v);
		if (got_v !== exp_v) begin
			$display("Error: %s is 0x%h, expected 0x%h", name, got_v, exp_v);
			$display("TEST FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic row(input logic v, input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] fm, input logic [4:0] f_t, input logic ill, input ctrl_t exp);
		row_t item;
		item = '{v, op, fn, fm, f_t, ill, exp};
		rows.push_back(item);
	endtask

	// Drive one instruction, check the registered result a cycle later
	task automatic run_row(input row_t r);
		logic [ALU_OP_W-1:0] exp_op;
		ctrl_t exp_c;
		exp_op = r.valid ? {r.op, r.fn} : '0; // Opcode then funct
		exp_c = r.valid ? r.exp : CTRL_NONE; // Bubble clears everything
		@(posedge clk);
		instr_valid <= r.valid;
		opcode <= r.op;
		funct <= r.fn;
		fmt <= r.fm;
		ft <= r.f_t;
		@(posedge clk);
		@(negedge clk); // Outputs settled
		compare("ctrl_valid", 32'(ctrl_valid), 32'(r.valid));
		compare("illegal", 32'(illegal), 32'(r.valid & r.ill));
		compare("alu_op", 32'(alu_op), 32'(exp_op));
		compare("alu_src", 32'(alu_src), 32'(exp_c.alu_src));
		compare("mem_op", 32'(mem_op), 32'(exp_c.mem_op));
		compare("wb_sel", 32'(wb_sel), 32'(exp_c.wb_sel));
		compare("flags", 32'(got[15:0]), 32'(exp_c[15:0]));
	endtask

	task automatic build_table();
		row(1'b1, OP_SPECIAL, FN_SLL, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_SRL, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_AND, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_ADD, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_SUB, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_SUBU, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_OR, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_NOR, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_SLT, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_SLTU, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_SPECIAL, FN_JR, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_LINK, 16'hc100));
		row(1'b1, OP_SPECIAL, FN_LW, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_READ, WB_MEM, 16'h0060));
		row(1'b1, OP_SPECIAL, FN_SW, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_WRITE, WB_NONE, 16'h0060));
		row(1'b1, OP_ADDI, 6'h2d, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_NONE, WB_ALU, 16'h0040));
		row(1'b1, OP_ADDIU, 6'h2d, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_NONE, WB_ALU, 16'h0040));
		row(1'b1, OP_ANDI, 6'h2d, 5'h0, 5'h0, 1'b0, mk(SRC_ZIMM, MEM_NONE, WB_ALU, 16'h0000));
		row(1'b1, OP_ORI, 6'h2d, 5'h0, 5'h0, 1'b0, mk(SRC_ZIMM, MEM_NONE, WB_ALU, 16'h0040));
		row(1'b1, OP_LUI, 6'h2d, 5'h0, 5'h0, 1'b0, mk(SRC_ZIMM, MEM_NONE, WB_ALU, 16'h0040));
		row(1'b1, OP_BEQ, 6'h11, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_NONE, 16'h1000));
		row(1'b1, OP_BNE, 6'h11, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0800));
		row(1'b1, OP_LW, 6'h3a, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0040));
		row(1'b1, OP_LBU, 6'h3a, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0050));
		row(1'b1, OP_SW, 6'h3a, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0040));
		row(1'b1, OP_SB, 6'h3a, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0048));
		row(1'b1, OP_J, 6'h07, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_NONE, 16'h8100));
		row(1'b1, OP_JAL, 6'h07, 5'h0, 5'h0, 1'b0, mk(SRC_REG, MEM_NONE, WB_LINK, 16'he100));
		row(1'b1, OP_LWC1, 6'h00, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0042));
		row(1'b1, OP_LDC1, 6'h00, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_READ, WB_MEM, 16'h0046));
		row(1'b1, OP_SWC1, 6'h00, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0042));
		row(1'b1, OP_SDC1, 6'h00, 5'h0, 5'h0, 1'b0, mk(SRC_SIMM, MEM_WRITE, WB_NONE, 16'h0046));
		row(1'b1, OP_COP1, 6'h00, FMT_BC, FT_T, 1'b0, mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0580));
		row(1'b1, OP_COP1, 6'h00, FMT_BC, FT_F, 1'b0, mk(SRC_REG, MEM_NONE, WB_NONE, 16'h0380));
		row(1'b1, OP_COP1, FN_FADD, FMT_S, 5'h3, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0002));
		row(1'b1, OP_COP1, FN_FADD, FMT_D, 5'h3, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0002));
		row(1'b1, OP_COP1, FN_FCMP_A, FMT_S, 5'h4, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0003));
		row(1'b1, OP_COP1, FN_FCMP_B, FMT_D, 5'h4, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0003));
		row(1'b1, OP_COP1, FN_FCMP_C, FMT_S, 5'h4, 1'b0, mk(SRC_REG, MEM_NONE, WB_ALU, 16'h0003));
		row(1'b1, 6'h3f, 6'h20, 5'h0, 5'h0, 1'b1, CTRL_NONE); // Unknown opcode
		row(1'b1, OP_SPECIAL, 6'h3f, 5'h0, 5'h0, 1'b1, CTRL_NONE); // Unknown funct
		row(1'b1, OP_COP1, FN_FADD, 5'h01, 5'h0, 1'b1, CTRL_NONE); // Unknown fmt
		row(1'b1, OP_COP1, 6'h00, FMT_BC, 5'h2, 1'b1, CTRL_NONE); // Unlisted ft
		row(1'b1, OP_COP1, 6'h01, FMT_D, 5'h0, 1'b1, CTRL_NONE); // Unlisted FP funct
		row(1'b0, OP_LW, 6'h00, 5'h0, 5'h0, 1'b0, CTRL_NONE); // Bubble
	endtask

	initial begin
		logic [31:0] a;
		logic [31:0] b;
		logic [5:0] op;
		logic [4:0] fm;
		logic hit;
		row_t rr;
		reset <= 1'b1;
		instr_valid <= 1'b1; // A live instruction that reset must override
		opcode <= OP_JAL;
		funct <= FN_ADD;
		fmt <= '0;
		ft <= '0;
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		instr_valid <= 1'b0;
		@(negedge clk);
		compare("ctrl_valid", 32'(ctrl_valid), 32'h0); // Cleared by reset
		compare("illegal", 32'(illegal), 32'h0);
		compare("alu_op", 32'(alu_op), 32'h0);
		compare("controls", 32'(got), 32'h0);
		foreach (rows[i]) begin
			run_row(rows[i]);
		end
		for (int i = 0; i < N_RAND; i++) begin
			a = lcg_next();
			b = lcg_next();
			// Bias toward the special and COP1 groups
			op = (a[31:30] == 2'd0) ? OP_SPECIAL : (a[31:30] == 2'd1) ? OP_COP1 : a[29:24];
			fm = (b[31:30] == 2'd0) ? FMT_BC : (b[31:30] == 2'd1) ? FMT_S :
				(b[31:30] == 2'd2) ? FMT_D : b[29:25];
			rr.valid = b[17] | b[16]; // Mostly valid
			rr.op = op;
			rr.fn = a[23:18];
			rr.fm = fm;
			rr.f_t = b[24] ? b[23:19] : {4'h0, b[18]};
			rr.exp = model(rr.op, rr.fn, rr.fm, rr.f_t, hit);
			rr.ill = !hit;
			run_row(rr);
		end
		$display("TEST PASS");
		$finish;
	end

	// Watchdog sized from the table and the random run
	initial begin
		#1;
		#(PERIOD * (RESET_CYCLES + 3 * (rows.size() + N_RAND) + 10));
		$display("Watchdog expired before all instructions were checked");
		$display("TEST FAIL");
		$fatal(1, "Timeout");
	end

endmodule

// ==== hw/control_unit.sv ====
/* Registered decode stage */
module control_unit
	import decode_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [OPCODE_W-1:0] opcode,
	input logic [FUNCT_W-1:0] funct,
	input logic [FMT_W-1:0] fmt,
	input logic [FT_W-1:0] ft,
	output logic ctrl_valid,
	output logic illegal,
	output logic [ALU_OP_W-1:0] alu_op,
	output alu_src_e alu_src,
	output mem_op_e mem_op,
	output wb_sel_e wb_sel,
	output logic jump,
	output logic jump_reg,
	output logic jal,
	output logic branch_eq,
	output logic branch_ne,
	output logic bc1t,
	output logic bc1f,
	output logic if_flush,
	output logic id_flush,
	output logic reg_dst,
	output logic rt_rd,
	output logic load_byte,
	output logic store_byte,
	output logic mem64,
	output logic float_op,
	output logic fp_write
);

	ctrl_if special_bus (); // Register group result
	ctrl_if main_bus (); // Integer and FP memory result
	ctrl_if cop1_bus (); // FP group result

	logic any_hit; // Some decoder knows the encoding
	ctrl_t merged; // Controls of the hitting decoder
	ctrl_t ctrl_q; // Stage register

	special_decode u_special (
		.opcode (opcode_e'(opcode)),
		.funct (funct_e'(funct)),
		.out (special_bus)
	);

	main_decode u_main (
		.opcode (opcode_e'(opcode)),
		.out (main_bus)
	);

	cop1_decode u_cop1 (
		.opcode (opcode_e'(opcode)),
		.fmt (fmt_e'(fmt)),
		.ft (ft),
		.funct (fp_funct_e'(funct)),
		.out (cop1_bus)
	);

	// Groups are disjoint so a plain OR selects the single hit
	assign any_hit = special_bus.hit | main_bus.hit | cop1_bus.hit;
	assign merged = ctrl_t'(special_bus.ctrl | main_bus.ctrl | cop1_bus.ctrl);

	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_valid <= 1'b0;
			illegal <= 1'b0;
			alu_op <= '0;
			ctrl_q <= CTRL_NONE;
		end else if (instr_valid) begin
			ctrl_valid <= 1'b1;
			illegal <= !any_hit; // Merge is all zero here
			alu_op <= {opcode, funct}; // Kept for every instruction
			ctrl_q <= merged;
		end else begin
			ctrl_valid <= 1'b0; // Bubble
			illegal <= 1'b0;
			alu_op <= '0;
			ctrl_q <= CTRL_NONE;
		end
	end

	assign alu_src = ctrl_q.alu_src;
	assign mem_op = ctrl_q.mem_op;
	assign wb_sel = ctrl_q.wb_sel;
	assign jump = ctrl_q.jump;
	assign jump_reg = ctrl_q.jump_reg;
	assign jal = ctrl_q.jal;
	assign branch_eq = ctrl_q.branch_eq;
	assign branch_ne = ctrl_q.branch_ne;
	assign bc1t = ctrl_q.bc1t;
	assign bc1f = ctrl_q.bc1f;
	assign if_flush = ctrl_q.if_flush;
	assign id_flush = ctrl_q.id_flush;
	assign reg_dst = ctrl_q.reg_dst;
	assign rt_rd = ctrl_q.rt_rd;
	assign load_byte = ctrl_q.load_byte;
	assign store_byte = ctrl_q.store_byte;
	assign mem64 = ctrl_q.mem64;
	assign float_op = ctrl_q.float_op;
	assign fp_write = ctrl_q.fp_write;

endmodule

// ==== hw/decode/cop1_decode.sv ====
/* Coprocessor-1 decoder */
module cop1_decode
	import decode_pkg::*;
(
	input opcode_e opcode,
	input fmt_e fmt,
	input logic [FT_W-1:0] ft,
	input fp_funct_e funct,
	ctrl_if.decoder out
);

	logic dec_hit;
	ctrl_t dec_ctrl;

	always_comb begin
		dec_hit = 1'b0;
		dec_ctrl = CTRL_NONE;
		if (opcode == OP_COP1) begin
			case (fmt)
				FMT_BC: begin
					// ft picks the branch sense, other values are undefined
					if (ft == FT_T || ft == FT_F) begin
						dec_hit = 1'b1;
						dec_ctrl.bc1t = (ft == FT_T);
						dec_ctrl.bc1f = (ft == FT_F);
						dec_ctrl.if_flush = 1'b1; // Resolved in decode
						dec_ctrl.id_flush = 1'b1;
					end
				end
				FMT_S,
				FMT_D: begin
					case (funct)
						FN_FADD: begin
							dec_hit = 1'b1;
							dec_ctrl.float_op = 1'b1;
							dec_ctrl.wb_sel = WB_ALU; // FP register result
						end
						FN_FCMP_A,
						FN_FCMP_B,
						FN_FCMP_C: begin
							dec_hit = 1'b1;
							dec_ctrl.float_op = 1'b1;
							dec_ctrl.fp_write = 1'b1; // Sets condition flag
							dec_ctrl.wb_sel = WB_ALU;
						end
						default: dec_hit = 1'b0;
					endcase
				end
				default: dec_hit = 1'b0; // Unknown format
			endcase
		end
	end

	assign out.hit = dec_hit;
	assign out.ctrl = dec_ctrl;

endmodule

// ==== hw/decode/main_decode.sv ====
/* Integer and FP memory opcode decoder */
module main_decode
	import decode_pkg::*;
(
	input opcode_e opcode,
	ctrl_if.decoder out
);

	logic dec_hit; // Opcode belongs to this group
	ctrl_t dec_ctrl;
	logic is_fp_mem; // FP load or store
	logic is_dword; // Double-word FP access

	assign is_fp_mem = (opcode == OP_LWC1) || (opcode == OP_LDC1) ||
		(opcode == OP_SWC1) || (opcode == OP_SDC1);
	assign is_dword = (opcode == OP_LDC1) || (opcode == OP_SDC1);

	always_comb begin
		dec_hit = 1'b1;
		dec_ctrl = CTRL_NONE;
		case (opcode)
			OP_ADDI,
			OP_ADDIU: begin
				dec_ctrl.alu_src = SRC_SIMM; // Sign-extended immediate
				dec_ctrl.reg_dst = 1'b1;
				dec_ctrl.wb_sel = WB_ALU;
			end
			OP_ANDI: begin
				dec_ctrl.alu_src = SRC_ZIMM; // Zero-extended immediate
				dec_ctrl.wb_sel = WB_ALU;
			end
			OP_ORI,
			OP_LUI: begin
				dec_ctrl.alu_src = SRC_ZIMM;
				dec_ctrl.reg_dst = 1'b1;
				dec_ctrl.wb_sel = WB_ALU;
			end
			OP_BEQ: dec_ctrl.branch_eq = 1'b1;
			OP_BNE: dec_ctrl.branch_ne = 1'b1;
			// Loads share one entry, the variants set their own flags
			OP_LW,
			OP_LBU,
			OP_LWC1,
			OP_LDC1: begin
				dec_ctrl.alu_src = SRC_SIMM; // Base plus offset
				dec_ctrl.reg_dst = 1'b1;
				dec_ctrl.mem_op = MEM_READ;
				dec_ctrl.wb_sel = WB_MEM;
				dec_ctrl.load_byte = (opcode == OP_LBU);
				dec_ctrl.float_op = is_fp_mem;
				dec_ctrl.mem64 = is_dword;
			end
			OP_SW,
			OP_SB,
			OP_SWC1,
			OP_SDC1: begin
				dec_ctrl.alu_src = SRC_SIMM;
				dec_ctrl.reg_dst = 1'b1;
				dec_ctrl.mem_op = MEM_WRITE;
				dec_ctrl.store_byte = (opcode == OP_SB);
				dec_ctrl.float_op = is_fp_mem;
				dec_ctrl.mem64 = is_dword;
			end
			OP_J: begin
				dec_ctrl.jump = 1'b1;
				dec_ctrl.if_flush = 1'b1; // Drop the sequential fetch
			end
			OP_JAL: begin
				dec_ctrl.jump = 1'b1;
				dec_ctrl.jump_reg = 1'b1;
				dec_ctrl.jal = 1'b1; // Link address to ra
				dec_ctrl.if_flush = 1'b1;
				dec_ctrl.wb_sel = WB_LINK;
			end
			default: begin
				dec_hit = 1'b0; // Special, COP1 or unknown
			end
		endcase
	end

	assign out.hit = dec_hit;
	assign out.ctrl = dec_ctrl;

endmodule

// ==== hw/decode/special_decode.sv ====
/* Special group decoder */
module special_decode
	import decode_pkg::*;
(
	input opcode_e opcode,
	input funct_e funct,
	ctrl_if.decoder out
);

	logic dec_hit; // Listed funct seen
	ctrl_t dec_ctrl; // Controls for that funct

	always_comb begin
		dec_hit = 1'b0;
		dec_ctrl = CTRL_NONE;
		if (opcode == OP_SPECIAL) begin
			dec_hit = 1'b1; // Dropped again for unlisted funct
			case (funct)
				FN_SLL,
				FN_SRL,
				FN_AND,
				FN_ADD,
				FN_SUB,
				FN_SUBU,
				FN_OR,
				FN_NOR,
				FN_SLT,
				FN_SLTU: begin
					dec_ctrl.wb_sel = WB_ALU; // Register ALU result
				end
				FN_JR: begin
					dec_ctrl.jump = 1'b1;
					dec_ctrl.jump_reg = 1'b1; // Target from rs
					dec_ctrl.if_flush = 1'b1; // Kill the fetched slot
					dec_ctrl.wb_sel = WB_LINK;
				end
				FN_LW: begin
					dec_ctrl.reg_dst = 1'b1;
					dec_ctrl.rt_rd = 1'b1; // Address from register pair
					dec_ctrl.mem_op = MEM_READ;
					dec_ctrl.wb_sel = WB_MEM;
				end
				FN_SW: begin
					dec_ctrl.reg_dst = 1'b1;
					dec_ctrl.rt_rd = 1'b1;
					dec_ctrl.mem_op = MEM_WRITE; // No write-back
				end
				default: begin
					dec_hit = 1'b0; // Unknown funct
				end
			endcase
		end
	end

	assign out.hit = dec_hit;
	assign out.ctrl = dec_ctrl;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the decode stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --assert --top-module control_unit_tb -f sources.f -o control_unit_sim \
	&& ./obj_dir/control_unit_sim > sim.log 2>&1 \
	|| echo "TEST FAIL" >> sim.log
if grep -q "TEST FAIL" sim.log; then
	echo "Simulation failed, see sim.log"
	exit 1
fi
echo "Simulation passed"

// ==== sources.f ====
common/decode_pkg.sv
common/ctrl_if.sv
hw/decode/special_decode.sv
hw/decode/main_decode.sv
hw/decode/cop1_decode.sv
hw/control_unit.sv
dv/control_unit_asserts.sv
dv/control_unit_tb.sv
